//--- cp0_defines.svh
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

// Datapath and field widths
`define CP0_DATA_W          32
`define CP0_EXT_INT_W       6
`define CP0_IM_W            8
`define CP0_EXC_W           5

// Reset values and constants
`define CP0_STATUS_BEV_RST  1'b1
`define CP0_PC_STEP         4

// Status bit positions
`define CP0_STATUS_CU0      28
`define CP0_STATUS_BEV      22
`define CP0_STATUS_IM_HI    15
`define CP0_STATUS_IM_LO    8
`define CP0_STATUS_UM       4
`define CP0_STATUS_ERL      2
`define CP0_STATUS_EXL      1
`define CP0_STATUS_IE       0

// Cause bit positions
`define CP0_CAUSE_BD        31
`define CP0_CAUSE_TI        30
`define CP0_CAUSE_IP_HI     15
`define CP0_CAUSE_IP_LO     8
`define CP0_CAUSE_EXC_HI    6
`define CP0_CAUSE_EXC_LO    2

`endif

//--- cp0_pkg.sv
`include "cp0_defines.svh"

package cp0_pkg;

    // CP0 register address, {rd, sel}
    typedef enum logic [7:0] {
        BADVADDR = 8'h40,
        COUNT    = 8'h48,
        COMPARE  = 8'h58,
        STATUS   = 8'h60,
        CAUSE    = 8'h68,
        EPC      = 8'h70
    } cp0_reg_e;

    // Exception type as reported by the memory stage
    typedef enum logic [`CP0_EXC_W-1:0] {
        EXC_NONE = 5'd0,
        EXC_INT  = 5'd1,
        EXC_ADEL = 5'd2,
        EXC_ADES = 5'd3,
        EXC_SYS  = 5'd4,
        EXC_BP   = 5'd5,
        EXC_RI   = 5'd6,
        EXC_OV   = 5'd7
    } exc_type_e;

    // Architectural Cause.ExcCode
    typedef enum logic [`CP0_EXC_W-1:0] {
        CODE_INT  = 5'd0,
        CODE_ADEL = 5'd4,
        CODE_ADES = 5'd5,
        CODE_SYS  = 5'd8,
        CODE_BP   = 5'd9,
        CODE_RI   = 5'd10,
        CODE_OV   = 5'd12,
        CODE_NONE = 5'd31
    } exc_code_e;

endpackage

//--- cp0_access_decode.sv
`timescale 1ns/10ps

module cp0_access_decode (
    input  logic               valid,
    input  logic               inst_mtc0,
    input  logic               inst_eret,
    input  logic               ex,
    input  logic [4:0]         rd,
    input  logic [2:0]         sel,
    output cp0_pkg::cp0_reg_e  reg_sel,
    output logic               status_we,
    output logic               cause_we,
    output logic               count_we,
    output logic               compare_we,
    output logic               epc_we,
    output logic               exc_commit,
    output logic               eret_flush
);

    logic mtc0_ok; // MTC0 that is allowed to retire

    assign reg_sel = cp0_pkg::cp0_reg_e'({rd, sel}); // Same address space for MTC0 and MFC0

    assign mtc0_ok = valid && inst_mtc0 && !ex;

    // One-hot write strobes
    assign status_we  = mtc0_ok && (reg_sel == cp0_pkg::STATUS);
    assign cause_we   = mtc0_ok && (reg_sel == cp0_pkg::CAUSE);
    assign count_we   = mtc0_ok && (reg_sel == cp0_pkg::COUNT);
    assign compare_we = mtc0_ok && (reg_sel == cp0_pkg::COMPARE);
    assign epc_we     = mtc0_ok && (reg_sel == cp0_pkg::EPC);

    assign exc_commit = valid && ex;
    assign eret_flush = valid && inst_eret && !ex; // Pipeline flush in the same cycle

endmodule

//--- cp0_status.sv
`timescale 1ns/10ps
`include "cp0_defines.svh"

module cp0_status (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   status_we,
    input  logic                   exc_commit,
    input  logic                   eret_flush,
    input  logic [`CP0_DATA_W-1:0] wdata,
    output logic                   cu0,
    output logic                   bev,
    output logic                   um,
    output logic                   erl,
    output logic                   exl,
    output logic                   ie,
    output logic [`CP0_IM_W-1:0]   im
);

    // Software-only fields
    always_ff @(posedge clk) begin
        if (reset) begin
            cu0 <= 1'b0;
            bev <= `CP0_STATUS_BEV_RST; // Boot vectors after reset
            im  <= '0;
            um  <= 1'b0;
            erl <= 1'b0;
            ie  <= 1'b0;
        end else if (status_we) begin
            cu0 <= wdata[`CP0_STATUS_CU0];
            bev <= wdata[`CP0_STATUS_BEV];
            im  <= wdata[`CP0_STATUS_IM_HI:`CP0_STATUS_IM_LO];
            um  <= wdata[`CP0_STATUS_UM];
            erl <= wdata[`CP0_STATUS_ERL];
            ie  <= wdata[`CP0_STATUS_IE];
        end
    end

    // EXL is the exception-level state
    always_ff @(posedge clk) begin
        if (reset) begin
            exl <= 1'b0;
        end else if (exc_commit) begin
            exl <= 1'b1; // Enter exception level
        end else if (eret_flush) begin
            exl <= 1'b0; // Return from handler
        end else if (status_we) begin
            exl <= wdata[`CP0_STATUS_EXL];
        end
    end

endmodule

//--- cp0_timer.sv
`timescale 1ns/10ps
`include "cp0_defines.svh"

module cp0_timer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   count_we,
    input  logic                   compare_we,
    input  logic [`CP0_DATA_W-1:0] wdata,
    output logic [`CP0_DATA_W-1:0] count,
    output logic [`CP0_DATA_W-1:0] compare,
    output logic                   timer_irq
);

    logic tick; // Half-rate phase for Count
    logic count_hit;

    assign count_hit = (count == compare);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick; // Free running, MTC0 leaves the phase alone
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (count_we) begin
            count <= wdata;
        end else if (tick) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= '0;
        end else if (compare_we) begin
            compare <= wdata;
        end
    end

    // Sticky TI, the Compare write acknowledges it
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_irq <= 1'b0;
        end else if (compare_we) begin
            timer_irq <= 1'b0; // Clear beats set
        end else if (count_hit) begin
            timer_irq <= 1'b1;
        end
    end

endmodule

//--- cp0_cause.sv
`timescale 1ns/10ps
`include "cp0_defines.svh"

module cp0_cause (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cause_we,
    input  logic                     exc_commit,
    input  logic                     bd,
    input  logic                     exl,
    input  logic                     timer_irq,
    input  cp0_pkg::exc_type_e       exc_type,
    input  logic [`CP0_EXT_INT_W-1:0] ext_int,
    input  logic [`CP0_DATA_W-1:0]   wdata,
    output logic                     cause_bd,
    output logic [`CP0_IM_W-1:0]     cause_ip,
    output cp0_pkg::exc_code_e       exc_code
);

    cp0_pkg::exc_code_e code_map; // ExcCode for the reported type

    always_comb begin
        case (exc_type)
            cp0_pkg::EXC_INT:  code_map = cp0_pkg::CODE_INT;
            cp0_pkg::EXC_ADEL: code_map = cp0_pkg::CODE_ADEL;
            cp0_pkg::EXC_ADES: code_map = cp0_pkg::CODE_ADES;
            cp0_pkg::EXC_SYS:  code_map = cp0_pkg::CODE_SYS;
            cp0_pkg::EXC_BP:   code_map = cp0_pkg::CODE_BP;
            cp0_pkg::EXC_RI:   code_map = cp0_pkg::CODE_RI;
            cp0_pkg::EXC_OV:   code_map = cp0_pkg::CODE_OV;
            default:           code_map = cp0_pkg::CODE_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exc_code <= cp0_pkg::CODE_NONE;
        end else if (exc_commit) begin
            exc_code <= code_map; // Nested exceptions still update the code
        end
    end

    // BD only describes the first exception
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd <= 1'b0;
        end else if (exc_commit && !exl) begin
            cause_bd <= bd;
        end
    end

    // Hardware pending bits, sampled every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_ip[`CP0_IM_W-1:2] <= '0;
        end else begin
            cause_ip[7]   <= ext_int[5] | timer_irq; // Timer shares IP7
            cause_ip[6:2] <= ext_int[4:0];
        end
    end

    // Software interrupt bits
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_ip[1:0] <= 2'b00;
        end else if (cause_we) begin
            cause_ip[1:0] <= wdata[`CP0_CAUSE_IP_LO+1:`CP0_CAUSE_IP_LO];
        end
    end

endmodule

//--- cp0_exc_capture.sv
`timescale 1ns/10ps
`include "cp0_defines.svh"

module cp0_exc_capture (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   exc_commit,
    input  logic                   epc_we,
    input  logic                   bd,
    input  logic                   exl,
    input  cp0_pkg::exc_type_e     exc_type,
    input  logic [`CP0_DATA_W-1:0] pc,
    input  logic [`CP0_DATA_W-1:0] wdata,
    output logic [`CP0_DATA_W-1:0] epc,
    output logic [`CP0_DATA_W-1:0] badvaddr
);

    logic [`CP0_DATA_W-1:0] epc_entry; // Restart address of the faulting instruction
    logic                   pc_misaligned;

    // In a delay slot the handler must restart at the branch
    assign epc_entry     = bd ? (pc - `CP0_PC_STEP) : pc;
    assign pc_misaligned = (pc[1:0] != 2'b00);

    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
        end else if (exc_commit && !exl) begin
            epc <= epc_entry;
        end else if (epc_we) begin
            epc <= wdata;
        end
    end

    // Read-only to software
    always_ff @(posedge clk) begin
        if (reset) begin
            badvaddr <= '0;
        end else if (exc_commit) begin
            if (exc_type == cp0_pkg::EXC_ADES) begin
                badvaddr <= wdata; // Store address from the ALU
            end else if (exc_type == cp0_pkg::EXC_ADEL) begin
                badvaddr <= pc_misaligned ? pc : wdata; // Fetch fault or load fault
            end
        end
    end

endmodule

//--- cp0_read_mux.sv
`timescale 1ns/10ps
`include "cp0_defines.svh"

module cp0_read_mux (
    input  cp0_pkg::cp0_reg_e      reg_sel,
    input  logic                   cu0,
    input  logic                   bev,
    input  logic [`CP0_IM_W-1:0]   im,
    input  logic                   um,
    input  logic                   erl,
    input  logic                   exl,
    input  logic                   ie,
    input  logic                   cause_bd,
    input  logic                   timer_irq,
    input  logic [`CP0_IM_W-1:0]   cause_ip,
    input  cp0_pkg::exc_code_e     exc_code,
    input  logic [`CP0_DATA_W-1:0] count,
    input  logic [`CP0_DATA_W-1:0] compare,
    input  logic [`CP0_DATA_W-1:0] epc,
    input  logic [`CP0_DATA_W-1:0] badvaddr,
    output logic [`CP0_DATA_W-1:0] rdata
);

    always_comb begin
        rdata = '0; // Reserved bits and unimplemented registers
        case (reg_sel)
            cp0_pkg::BADVADDR: rdata = badvaddr;
            cp0_pkg::COUNT:    rdata = count;
            cp0_pkg::COMPARE:  rdata = compare;
            cp0_pkg::EPC:      rdata = epc;
            cp0_pkg::STATUS: begin
                rdata[`CP0_STATUS_CU0]                      = cu0;
                rdata[`CP0_STATUS_BEV]                      = bev;
                rdata[`CP0_STATUS_IM_HI:`CP0_STATUS_IM_LO]  = im;
                rdata[`CP0_STATUS_UM]                       = um;
                rdata[`CP0_STATUS_ERL]                      = erl;
                rdata[`CP0_STATUS_EXL]                      = exl;
                rdata[`CP0_STATUS_IE]                       = ie;
            end
            cp0_pkg::CAUSE: begin
                rdata[`CP0_CAUSE_BD]                        = cause_bd;
                rdata[`CP0_CAUSE_TI]                        = timer_irq;
                rdata[`CP0_CAUSE_IP_HI:`CP0_CAUSE_IP_LO]    = cause_ip;
                rdata[`CP0_CAUSE_EXC_HI:`CP0_CAUSE_EXC_LO]  = exc_code;
            end
            default: rdata = '0;
        endcase
    end

endmodule

//--- cp0_top.sv
`timescale 1ns/10ps
`include "cp0_defines.svh"

module cp0_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      valid,
    input  logic                      inst_mtc0,
    input  logic                      inst_eret,
    input  logic                      ex,
    input  logic                      bd,
    input  logic [4:0]                rd,
    input  logic [2:0]                sel,
    input  logic [`CP0_DATA_W-1:0]    wdata,
    input  logic [`CP0_DATA_W-1:0]    pc,
    input  cp0_pkg::exc_type_e        exc_type,
    input  logic [`CP0_EXT_INT_W-1:0] ext_int,
    output logic [`CP0_DATA_W-1:0]    rdata,
    output logic                      eret_flush,
    output logic [`CP0_DATA_W-1:0]    epc,
    output logic                      status_ie,
    output logic                      status_exl,
    output logic [`CP0_IM_W-1:0]      status_im,
    output logic [`CP0_IM_W-1:0]      cause_ip,
    output logic                      cause_ti
);

    cp0_pkg::cp0_reg_e      reg_sel;
    logic                   status_we;
    logic                   cause_we;
    logic                   count_we;
    logic                   compare_we;
    logic                   epc_we;
    logic                   exc_commit;
    logic                   cu0;
    logic                   bev;
    logic                   um;
    logic                   erl;
    logic                   cause_bd;
    cp0_pkg::exc_code_e     exc_code;
    logic [`CP0_DATA_W-1:0] count;
    logic [`CP0_DATA_W-1:0] compare;
    logic [`CP0_DATA_W-1:0] badvaddr;

    cp0_access_decode cp0_access_decode_inst (
        .valid      (valid),
        .inst_mtc0  (inst_mtc0),
        .inst_eret  (inst_eret),
        .ex         (ex),
        .rd         (rd),
        .sel        (sel),
        .reg_sel    (reg_sel),
        .status_we  (status_we),
        .cause_we   (cause_we),
        .count_we   (count_we),
        .compare_we (compare_we),
        .epc_we     (epc_we),
        .exc_commit (exc_commit),
        .eret_flush (eret_flush)
    );

    cp0_status cp0_status_inst (
        .clk        (clk),
        .reset      (reset),
        .status_we  (status_we),
        .exc_commit (exc_commit),
        .eret_flush (eret_flush),
        .wdata      (wdata),
        .cu0        (cu0),
        .bev        (bev),
        .um         (um),
        .erl        (erl),
        .exl        (status_exl),
        .ie         (status_ie),
        .im         (status_im)
    );

    cp0_timer cp0_timer_inst (
        .clk        (clk),
        .reset      (reset),
        .count_we   (count_we),
        .compare_we (compare_we),
        .wdata      (wdata),
        .count      (count),
        .compare    (compare),
        .timer_irq  (cause_ti)
    );

    cp0_cause cp0_cause_inst (
        .clk        (clk),
        .reset      (reset),
        .cause_we   (cause_we),
        .exc_commit (exc_commit),
        .bd         (bd),
        .exl        (status_exl),
        .timer_irq  (cause_ti),
        .exc_type   (exc_type),
        .ext_int    (ext_int),
        .wdata      (wdata),
        .cause_bd   (cause_bd),
        .cause_ip   (cause_ip),
        .exc_code   (exc_code)
    );

    cp0_exc_capture cp0_exc_capture_inst (
        .clk        (clk),
        .reset      (reset),
        .exc_commit (exc_commit),
        .epc_we     (epc_we),
        .bd         (bd),
        .exl        (status_exl),
        .exc_type   (exc_type),
        .pc         (pc),
        .wdata      (wdata),
        .epc        (epc),
        .badvaddr   (badvaddr)
    );

    cp0_read_mux cp0_read_mux_inst (
        .reg_sel    (reg_sel),
        .cu0        (cu0),
        .bev        (bev),
        .im         (status_im),
        .um         (um),
        .erl        (erl),
        .exl        (status_exl),
        .ie         (status_ie),
        .cause_bd   (cause_bd),
        .timer_irq  (cause_ti),
        .cause_ip   (cause_ip),
        .exc_code   (exc_code),
        .count      (count),
        .compare    (compare),
        .epc        (epc),
        .badvaddr   (badvaddr),
        .rdata      (rdata)
    );

endmodule

//--- cp0_checker.sv
`timescale 1ns/10ps
`include "cp0_defines.svh"

module cp0_checker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      valid,
    input  logic                      inst_mtc0,
    input  logic                      inst_eret,
    input  logic                      ex,
    input  logic                      bd,
    input  logic [4:0]                rd,
    input  logic [2:0]                sel,
    input  logic [`CP0_DATA_W-1:0]    wdata,
    input  logic [`CP0_DATA_W-1:0]    pc,
    input  cp0_pkg::exc_type_e        exc_type,
    input  logic [`CP0_EXT_INT_W-1:0] ext_int,
    input  logic [`CP0_DATA_W-1:0]    rdata,
    input  logic                      eret_flush,
    input  logic [`CP0_DATA_W-1:0]    epc,
    input  logic                      status_ie,
    input  logic                      status_exl,
    input  logic [`CP0_IM_W-1:0]      status_im,
    input  logic [`CP0_IM_W-1:0]      cause_ip,
    input  logic                      cause_ti,
    output int                        mismatches,
    output int                        checks
);

    // Shadow of the architectural state
    logic        sh_cu0;
    logic        sh_bev;
    logic [7:0]  sh_im;
    logic        sh_um;
    logic        sh_erl;
    logic        sh_exl;
    logic        sh_ie;
    logic        sh_bd;
    logic        sh_ti;
    logic [7:0]  sh_ip;
    logic [4:0]  sh_code;
    logic [31:0] sh_count;
    logic [31:0] sh_compare;
    logic [31:0] sh_epc;
    logic [31:0] sh_badvaddr;
    logic        sh_tick;
    int          mismatch_count = 0;
    int          check_count = 0;

    assign mismatches = mismatch_count;
    assign checks     = check_count;

    // Architectural ExcCode for each reported type
    function automatic logic [4:0] code_of(input cp0_pkg::exc_type_e kind);
        case (kind)
            cp0_pkg::EXC_INT:  return 5'd0;
            cp0_pkg::EXC_ADEL: return 5'd4;
            cp0_pkg::EXC_ADES: return 5'd5;
            cp0_pkg::EXC_SYS:  return 5'd8;
            cp0_pkg::EXC_BP:   return 5'd9;
            cp0_pkg::EXC_RI:   return 5'd10;
            cp0_pkg::EXC_OV:   return 5'd12;
            default:           return 5'd31;
        endcase
    endfunction

    // Expected MFC0 word for the address {rd, sel}
    function automatic logic [31:0] expected_rdata(input logic [7:0] addr);
        logic [31:0] word;
        word = '0;
        case (addr)
            8'h40: word = sh_badvaddr;
            8'h48: word = sh_count;
            8'h58: word = sh_compare;
            8'h70: word = sh_epc;
            8'h60: begin
                word[`CP0_STATUS_CU0] = sh_cu0;
                word[`CP0_STATUS_BEV] = sh_bev;
                word[`CP0_STATUS_IM_HI:`CP0_STATUS_IM_LO] = sh_im;
                word[`CP0_STATUS_UM]  = sh_um;
                word[`CP0_STATUS_ERL] = sh_erl;
                word[`CP0_STATUS_EXL] = sh_exl;
                word[`CP0_STATUS_IE]  = sh_ie;
            end
            8'h68: begin
                word[`CP0_CAUSE_BD] = sh_bd;
                word[`CP0_CAUSE_TI] = sh_ti;
                word[`CP0_CAUSE_IP_HI:`CP0_CAUSE_IP_LO]   = sh_ip;
                word[`CP0_CAUSE_EXC_HI:`CP0_CAUSE_EXC_LO] = sh_code;
            end
            default: word = '0; // Unimplemented
        endcase
        return word;
    endfunction

    always @(posedge clk) begin : shadow_update
        logic [7:0] addr;
        logic       wr;
        logic       commit;
        logic       ret;
        logic       hit;
        addr   = {rd, sel};
        wr     = valid && inst_mtc0 && !ex;
        commit = valid && ex;
        ret    = valid && inst_eret && !ex;
        if (reset) begin
            {sh_cu0, sh_um, sh_erl, sh_exl, sh_ie, sh_bd, sh_ti, sh_tick} = '0;
            sh_bev = 1'b1;
            {sh_im, sh_ip} = '0;
            sh_code = 5'd31;
            {sh_count, sh_compare, sh_epc, sh_badvaddr} = '0;
        end else begin
            hit = (sh_count == sh_compare); // Old values
            if (wr && addr == 8'h60) begin
                sh_cu0 = wdata[28];
                sh_bev = wdata[22];
                sh_im  = wdata[15:8];
                sh_um  = wdata[4];
                sh_erl = wdata[2];
                sh_ie  = wdata[0];
            end
            if (commit && !sh_exl) begin
                sh_bd  = bd;
                sh_epc = bd ? pc - 32'd4 : pc; // Restart at the branch
            end else if (wr && addr == 8'h70) begin
                sh_epc = wdata;
            end
            if (commit) begin
                sh_code = code_of(exc_type);
                if (exc_type == cp0_pkg::EXC_ADES) begin
                    sh_badvaddr = wdata;
                end else if (exc_type == cp0_pkg::EXC_ADEL) begin
                    sh_badvaddr = (pc[1:0] != 2'b00) ? pc : wdata;
                end
            end
            if (commit) begin
                sh_exl = 1'b1;
            end else if (ret) begin
                sh_exl = 1'b0;
            end else if (wr && addr == 8'h60) begin
                sh_exl = wdata[1];
            end
            sh_ip[7:2] = {ext_int[5] | sh_ti, ext_int[4:0]}; // TI before this edge
            if (wr && addr == 8'h68) begin
                sh_ip[1:0] = wdata[9:8];
            end
            if (wr && addr == 8'h48) begin
                sh_count = wdata;
            end else if (sh_tick) begin
                sh_count = sh_count + 32'd1;
            end
            sh_tick = !sh_tick;
            if (wr && addr == 8'h58) begin
                sh_ti      = 1'b0; // Clear wins
                sh_compare = wdata;
            end else if (hit) begin
                sh_ti = 1'b1;
            end
        end
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            compare_word("rdata", rdata, expected_rdata({rd, sel}));
            compare_word("eret_flush", 32'(eret_flush), 32'(valid && inst_eret && !ex));
            compare_word("epc", epc, sh_epc);
            compare_word("status_ie", 32'(status_ie), 32'(sh_ie));
            compare_word("status_exl", 32'(status_exl), 32'(sh_exl));
            compare_word("status_im", 32'(status_im), 32'(sh_im));
            compare_word("cause_ip", 32'(cause_ip), 32'(sh_ip));
            compare_word("cause_ti", 32'(cause_ti), 32'(sh_ti));
        end
    end

endmodule

//--- cp0_tb.sv
`timescale 1ns/10ps
`include "cp0_defines.svh"

module cp0_tb;

    localparam int DIRECTED_CYCLES = 120; // Upper bound of the directed part
    localparam int RANDOM_CYCLES   = 200;

    logic                      clk;
    logic                      reset;
    logic                      valid;
    logic                      inst_mtc0;
    logic                      inst_eret;
    logic                      ex;
    logic                      bd;
    logic [4:0]                rd;
    logic [2:0]                sel;
    logic [`CP0_DATA_W-1:0]    wdata;
    logic [`CP0_DATA_W-1:0]    pc;
    cp0_pkg::exc_type_e        exc_type;
    logic [`CP0_EXT_INT_W-1:0] ext_int;
    logic [`CP0_DATA_W-1:0]    rdata;
    logic                      eret_flush;
    logic [`CP0_DATA_W-1:0]    epc;
    logic                      status_ie;
    logic                      status_exl;
    logic [`CP0_IM_W-1:0]      status_im;
    logic [`CP0_IM_W-1:0]      cause_ip;
    logic                      cause_ti;
    int                        mismatches;
    int                        checks;
    int                        seq_errors;
    integer                    seed;

    cp0_top cp0_top_inst (
        .clk(clk), .reset(reset), .valid(valid), .inst_mtc0(inst_mtc0),
        .inst_eret(inst_eret), .ex(ex), .bd(bd), .rd(rd), .sel(sel), .wdata(wdata),
        .pc(pc), .exc_type(exc_type), .ext_int(ext_int), .rdata(rdata),
        .eret_flush(eret_flush), .epc(epc), .status_ie(status_ie),
        .status_exl(status_exl), .status_im(status_im), .cause_ip(cause_ip),
        .cause_ti(cause_ti)
    );

    cp0_checker cp0_checker_inst (
        .clk(clk), .reset(reset), .valid(valid), .inst_mtc0(inst_mtc0),
        .inst_eret(inst_eret), .ex(ex), .bd(bd), .rd(rd), .sel(sel), .wdata(wdata),
        .pc(pc), .exc_type(exc_type), .ext_int(ext_int), .rdata(rdata),
        .eret_flush(eret_flush), .epc(epc), .status_ie(status_ie),
        .status_exl(status_exl), .status_im(status_im), .cause_ip(cause_ip),
        .cause_ti(cause_ti), .mismatches(mismatches), .checks(checks)
    );

    always #50 clk = ~clk;

    task automatic step;
        @(posedge clk);
        #1; // Drive just after the edge
    endtask

    task automatic clear_inputs;
        valid     = 1'b0;
        inst_mtc0 = 1'b0;
        inst_eret = 1'b0;
        ex        = 1'b0;
        bd        = 1'b0;
        exc_type  = cp0_pkg::EXC_NONE;
    endtask

    task automatic write_reg(input logic [4:0] r, input logic [2:0] s, input logic [31:0] d);
        clear_inputs();
        valid     = 1'b1;
        inst_mtc0 = 1'b1;
        {rd, sel} = {r, s};
        wdata     = d;
        step();
    endtask

    task automatic read_reg(input logic [4:0] r, input logic [2:0] s);
        clear_inputs();
        valid     = 1'b1; // MFC0 has no strobe
        {rd, sel} = {r, s};
        step();
    endtask

    task automatic raise_exc(input cp0_pkg::exc_type_e kind, input logic [31:0] addr,
                             input logic slot, input logic [31:0] data);
        clear_inputs();
        valid    = 1'b1;
        ex       = 1'b1;
        exc_type = kind;
        pc       = addr;
        bd       = slot;
        wdata    = data;
        step();
    endtask

    task automatic do_eret(input logic with_ex);
        clear_inputs();
        valid     = 1'b1;
        inst_eret = 1'b1;
        ex        = with_ex;
        exc_type  = with_ex ? cp0_pkg::EXC_INT : cp0_pkg::EXC_NONE;
        step();
    endtask

    task automatic wait_for_ti(input int limit);
        int n;
        n = 0;
        clear_inputs();
        {rd, sel} = 8'h68; // Watch Cause meanwhile
        while (!cause_ti && n < limit) begin
            step();
            n++;
        end
        if (!cause_ti) begin
            seq_errors++;
            $display("Timer interrupt did not rise within %0d cycles", limit);
        end
    endtask

    // Biased toward the implemented addresses
    function automatic logic [7:0] pick_address(input logic [31:0] r);
        case (r[2:0])
            3'd0: return 8'h40;
            3'd1: return 8'h48;
            3'd2: return 8'h58;
            3'd3: return 8'h60;
            3'd4: return 8'h68;
            3'd5: return 8'h70;
            default: return r[15:8];
        endcase
    endfunction

    task automatic random_instr;
        logic [31:0] r;
        logic [31:0] d;
        clear_inputs();
        r = $random(seed);
        d = $random(seed);
        ext_int   = r[29:24];
        {rd, sel} = pick_address(d);
        wdata     = $random(seed);
        pc        = $random(seed);
        if (r[3:0] < 4'd6) begin
            valid     = 1'b1;
            inst_mtc0 = 1'b1;
            ex        = (r[7:4] == 4'd0); // Rarely killed by an exception
            exc_type  = cp0_pkg::exc_type_e'({2'b00, r[10:8]});
        end else if (r[3:0] < 4'd8) begin
            valid    = 1'b1;
            ex       = 1'b1;
            bd       = r[11];
            exc_type = cp0_pkg::exc_type_e'({2'b00, r[10:8]});
        end else if (r[3:0] == 4'd8) begin
            valid     = 1'b1;
            inst_eret = 1'b1;
            ex        = (r[6:4] == 3'd0);
        end else begin
            valid = r[12];
        end
        step();
    endtask

    initial begin
        #((DIRECTED_CYCLES + RANDOM_CYCLES + 50) * 100);
        $display("Timeout: the test sequence did not finish in time");
        $display("Verification failed");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        clear_inputs();
        {rd, sel}  = 8'h00;
        wdata      = '0;
        pc         = '0;
        ext_int    = '0;
        seq_errors = 0;
        seed       = 32'he9c2_7503;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        repeat (4) read_reg(5'd9, 3'd0); // Count runs at half rate
        write_reg(5'd12, 3'd0, 32'hffff_ffff);
        read_reg(5'd12, 3'd0);
        write_reg(5'd12, 3'd0, 32'h1040_ff13);
        write_reg(5'd13, 3'd0, 32'hffff_ffff);
        read_reg(5'd13, 3'd0);
        write_reg(5'd14, 3'd0, 32'h1234_5678);
        read_reg(5'd14, 3'd0);
        write_reg(5'd9, 3'd0, 32'd100);
        repeat (2) read_reg(5'd9, 3'd0);
        clear_inputs();
        valid = 1'b1;
        inst_mtc0 = 1'b1;
        ex = 1'b1; // Killed write must not land
        exc_type = cp0_pkg::EXC_OV;
        {rd, sel} = 8'h70;
        wdata = 32'hdead_0000;
        step();
        read_reg(5'd14, 3'd0);
        read_reg(5'd15, 3'd0);
        read_reg(5'd16, 3'd1);
        read_reg(5'd12, 3'd1);
        write_reg(5'd12, 3'd0, 32'h0000_0000);

        raise_exc(cp0_pkg::EXC_SYS, 32'h8000_0100, 1'b0, 32'h0);
        read_reg(5'd14, 3'd0);
        read_reg(5'd13, 3'd0);
        read_reg(5'd12, 3'd0);
        raise_exc(cp0_pkg::EXC_RI, 32'h8000_0200, 1'b1, 32'h0); // Nested exception keeps EPC
        read_reg(5'd14, 3'd0);
        read_reg(5'd13, 3'd0);
        do_eret(1'b0);
        read_reg(5'd12, 3'd0);
        do_eret(1'b1);
        read_reg(5'd12, 3'd0);
        do_eret(1'b0);
        raise_exc(cp0_pkg::EXC_BP, 32'h8000_0300, 1'b1, 32'h0);
        read_reg(5'd14, 3'd0);
        read_reg(5'd13, 3'd0);
        do_eret(1'b0);
        raise_exc(cp0_pkg::EXC_ADES, 32'h8000_0400, 1'b0, 32'hdead_beef);
        read_reg(5'd8, 3'd0);
        do_eret(1'b0);
        raise_exc(cp0_pkg::EXC_ADEL, 32'h8000_0502, 1'b0, 32'h1111_2220);
        read_reg(5'd8, 3'd0);
        do_eret(1'b0);
        raise_exc(cp0_pkg::EXC_ADEL, 32'h8000_0600, 1'b0, 32'h2222_3333);
        read_reg(5'd8, 3'd0);
        do_eret(1'b0);

        write_reg(5'd9, 3'd0, 32'd0);
        write_reg(5'd11, 3'd0, 32'd8);
        wait_for_ti(40);
        read_reg(5'd13, 3'd0);
        write_reg(5'd11, 3'd0, 32'h0000_0100); // Acknowledge the timer
        read_reg(5'd11, 3'd0);
        repeat (2) read_reg(5'd13, 3'd0);

        ext_int = 6'h2a;
        repeat (2) read_reg(5'd13, 3'd0);
        ext_int = 6'h15;
        repeat (2) read_reg(5'd13, 3'd0);
        ext_int = 6'h00;
        repeat (2) read_reg(5'd13, 3'd0);

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            random_instr();
        end
        clear_inputs();
        repeat (2) step();

        $display("Closing report: %0d checks, %0d mismatches, %0d sequence errors",
                 checks, mismatches, seq_errors);
        if (mismatches == 0 && seq_errors == 0 && checks > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
cp0_pkg.sv
cp0_access_decode.sv
cp0_status.sv
cp0_timer.sv
cp0_cause.sv
cp0_exc_capture.sv
cp0_read_mux.sv
cp0_top.sv
cp0_checker.sv
cp0_tb.sv

//--- run.sh
#!/bin/sh
# Build the CP0 testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cp0_tb -f tb.f -o cp0_sim || exit 1

out="$(./obj_dir/cp0_sim)"
echo "$out"

echo "$out" | grep -qx "Verification passed" && exit 0 || exit 1
